/* list.f */
+incdir+rtl
rtl/vslide_pkg.sv
rtl/vslide_axil_regs.sv
rtl/vector_regfile.sv
rtl/vslide_sequencer.sv
rtl/vslide_permutation_unit.sv
rtl/vslide_top.sv
tb/vslide_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the slide engine testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module vslide_tb \
    -f list.f -o vslide_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/vslide_sim > sim.log 2>&1
grep -qx "PASS: all tests" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb/vslide_tb.sv */
// Directed testbench that drives vslide_top over AXI4-Lite and checks the slide results.
`include "vslide_defines.svh"

module vslide_tb
    import vslide_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_CMD    = 12'h000;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_VL     = 12'h004;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_OFFSET = 12'h008;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_RS1    = 12'h00C;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_STATUS = 12'h010;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic                        CLK;
    logic                        rst_n;
    logic [`VS_AXI_ADDR_W-1:0]   awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [`VS_AXI_DATA_W-1:0]   wdata;
    logic [`VS_AXI_DATA_W/8-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;
    logic [`VS_AXI_ADDR_W-1:0]   araddr;
    logic                        arvalid;
    logic                        arready;
    logic [`VS_AXI_DATA_W-1:0]   rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;

    elem_t       model [`VS_NUM_VREGS][`VS_VLMAX];    // Expected register file.
    logic [31:0] lfsr_state;
    string       test_name;

    vslide_top dut0 (.*);

    always #2 CLK = ~CLK;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic elem_t rand_elem();
        elem_t w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return w;
    endfunction

    function automatic elem_t cmd_word(input slide_op_e op, input int vd, input int vs2);
        return elem_t'((vs2 << 8) | (vd << 4) | int'(op));
    endfunction

    function automatic logic [`VS_AXI_ADDR_W-1:0] win_addr(input int r, input int e);
        return 12'h200 + 12'(r * 64 + e * 4);
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic report_timeout(input string what);
        $display("Test %s timed out waiting for %s.", test_name, what);
        abort_run();
    endtask

    task automatic check_elem(input string what, input elem_t exp, input elem_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %08h, actual %08h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected resp %0d, actual resp %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // Called and returning 0.5 ns after a rising edge.
    task automatic axi_write(input logic [11:0] addr, input elem_t data, output logic [1:0] resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!awready) begin
            @(posedge CLK);
            #0.5;
            n++;
            if (n > 20) report_timeout("awready");
        end
        if (wready !== 1'b1) begin
            $display("Test %s saw awready rise without wready.", test_name);
            abort_run();
        end
        @(posedge CLK);    // Handshake edge.
        #0.5;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(posedge CLK);
            #0.5;
            n++;
            if (n > 20) report_timeout("bvalid");
        end
        resp = bresp;
    endtask

    task automatic axi_read(input logic [11:0] addr, output elem_t data, output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(posedge CLK);
            #0.5;
            n++;
            if (n > 20) report_timeout("arready");
        end
        @(posedge CLK);
        #0.5;
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(posedge CLK);
            #0.5;
            n++;
            if (n > 20) report_timeout("rvalid");
        end
        data = rdata;
        resp = rresp;
    endtask

    task automatic write_ok(input logic [11:0] addr, input elem_t data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp($sformatf("write to %03h", addr), OKAY, resp);
    endtask

    task automatic wait_status(input logic busy_bit);
        elem_t      st;
        logic [1:0] resp;
        int         n;
        n = 0;
        st = {31'b0, !busy_bit};
        while (st[0] != busy_bit) begin
            axi_read(ADDR_STATUS, st, resp);
            check_resp("STATUS read", OKAY, resp);
            n++;
            if (n > 20) report_timeout($sformatf("STATUS busy to read %0b", busy_bit));
        end
    endtask

    task automatic check_regfile();
        elem_t      d;
        logic [1:0] resp;
        for (int r = 0; r < `VS_NUM_VREGS; r++) begin
            for (int e = 0; e < `VS_VLMAX; e++) begin
                axi_read(win_addr(r, e), d, resp);
                check_resp($sformatf("v%0d[%0d] read", r, e), OKAY, resp);
                check_elem($sformatf("v%0d[%0d]", r, e), model[r][e], d);
            end
        end
    endtask

    // Slide rules applied to the expected contents; only i below vl changes.
    task automatic model_slide(input slide_op_e op, input int vd, input int vs2, input int vl,
                               input int off, input elem_t rs1);
        elem_t src [`VS_VLMAX];
        src = model[vs2];
        for (int i = 0; i < vl; i++) begin
            case (op)
                SLIDE_UP:    if (i >= off) model[vd][i] = src[i - off];
                SLIDE_DOWN:  model[vd][i] = (i + off < `VS_VLMAX) ? src[i + off] : '0;
                SLIDE1_UP:   model[vd][i] = (i == 0) ? rs1 : src[i - 1];
                default:     model[vd][i] = (i == vl - 1) ? rs1 : src[i + 1];
            endcase
        end
    endtask

    task automatic run_slide(input slide_op_e op, input int vd, input int vs2, input int vl,
                             input int off, input elem_t rs1);
        write_ok(ADDR_VL, vl);
        write_ok(ADDR_OFFSET, off);
        write_ok(ADDR_RS1, rs1);
        write_ok(ADDR_CMD, cmd_word(op, vd, vs2));
        model_slide(op, vd, vs2, vl, off, rs1);
        wait_status(1'b1);
        wait_status(1'b0);
        check_regfile();
    endtask

    task automatic test_window();
        elem_t      d;
        logic [1:0] resp;
        test_name = "window";
        for (int r = 0; r < `VS_NUM_VREGS; r++) begin
            for (int e = 0; e < `VS_VLMAX; e++) begin
                model[r][e] = rand_elem();
                write_ok(win_addr(r, e), model[r][e]);
            end
        end
        check_regfile();
        write_ok(ADDR_VL, 25);
        axi_read(ADDR_VL, d, resp);
        check_resp("VL read", OKAY, resp);
        check_elem("VL clamped", 32'd16, d);
        write_ok(ADDR_OFFSET, 18);
        axi_read(ADDR_OFFSET, d, resp);
        check_resp("OFFSET read", OKAY, resp);
        check_elem("OFFSET", 32'd18, d);
        write_ok(ADDR_RS1, 32'hA5C3_0F96);
        axi_read(ADDR_RS1, d, resp);
        check_resp("RS1 read", OKAY, resp);
        check_elem("RS1", 32'hA5C3_0F96, d);
    endtask

    task automatic test_slides();
        int up_offs [4];
        int dn_offs [4];
        int vls [2];
        up_offs = '{0, 1, 5, 18};
        dn_offs = '{0, 3, 7, 14};
        vls = '{16, 11};
        for (int v = 0; v < 2; v++) begin
            for (int k = 0; k < 4; k++) begin
                test_name = $sformatf("slide_up off %0d vl %0d", up_offs[k], vls[v]);
                run_slide(SLIDE_UP, 1, 6, vls[v], up_offs[k], '0);
                test_name = $sformatf("slide_down off %0d vl %0d", dn_offs[k], vls[v]);
                run_slide(SLIDE_DOWN, 3, 0, vls[v], dn_offs[k], '0);
            end
        end
    endtask

    task automatic test_slide1();
        int vls [3];
        vls = '{16, 4, 1};
        for (int k = 0; k < 3; k++) begin
            test_name = $sformatf("slide1up vl %0d", vls[k]);
            run_slide(SLIDE1_UP, 4, 7, vls[k], 9, rand_elem());    // Offset is ignored.
            test_name = $sformatf("slide1down vl %0d", vls[k]);
            run_slide(SLIDE1_DOWN, 5, 6, vls[k], 9, rand_elem());
        end
    endtask

    task automatic test_errors();
        elem_t      d;
        logic [1:0] resp;
        test_name = "errors";
        axi_write(ADDR_CMD, cmd_word(SLIDE_DOWN, 3, 3), resp);
        check_resp("CMD with vd equal to vs2", SLVERR, resp);
        check_regfile();

        write_ok(ADDR_VL, 16);
        write_ok(ADDR_OFFSET, 6);
        write_ok(ADDR_CMD, cmd_word(SLIDE_DOWN, 5, 1));
        model_slide(SLIDE_DOWN, 5, 1, 16, 6, '0);
        wait_status(1'b1);
        axi_write(ADDR_CMD, cmd_word(SLIDE_UP, 6, 2), resp);
        check_resp("CMD while busy", SLVERR, resp);
        wait_status(1'b0);
        check_regfile();

        d = rand_elem();
        write_ok(ADDR_RS1, d);
        write_ok(ADDR_CMD, cmd_word(SLIDE1_UP, 0, 3));
        model_slide(SLIDE1_UP, 0, 3, 16, 6, d);
        wait_status(1'b1);
        axi_write(win_addr(7, 9), ~model[7][9], resp);    // Must be dropped.
        check_resp("window write while busy", SLVERR, resp);
        wait_status(1'b0);
        check_regfile();

        axi_read(12'h044, d, resp);
        check_resp("unmapped read", SLVERR, resp);
        axi_write(12'h100, 32'h1, resp);
        check_resp("unmapped write", SLVERR, resp);
    endtask

    task automatic test_recovery();
        elem_t      d;
        logic [1:0] resp;
        test_name = "recovery";
        axi_write(ADDR_CMD, cmd_word(SLIDE_UP, 4, 4), resp);
        check_resp("refused CMD", SLVERR, resp);
        run_slide(SLIDE_DOWN, 2, 4, 13, 2, '0);
        axi_read(ADDR_STATUS, d, resp);
        check_resp("STATUS read", OKAY, resp);
        check_elem("STATUS after slide", '0, d);
    endtask

    initial begin
        CLK        = 1'b0;
        rst_n      = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '1;
        wvalid     = 1'b0;
        bready     = 1'b1;    // Responses are always taken at once.
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        lfsr_state = 32'd3;
        test_name  = "reset";
        for (int r = 0; r < `VS_NUM_VREGS; r++) begin
            for (int e = 0; e < `VS_VLMAX; e++) model[r][e] = '0;
        end
        repeat (3) @(posedge CLK);
        #0.5;
        rst_n = 1'b1;

        test_window();
        test_slides();
        test_slide1();
        test_errors();
        test_recovery();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* rtl/vslide_top.sv */
// Top of the vector slide engine, joins host interface, register file, sequencer and permutation.
`include "vslide_defines.svh"

module vslide_top
    import vslide_pkg::*;
(
    input  logic                        CLK,
    input  logic                        rst_n,
    input  logic [`VS_AXI_ADDR_W-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`VS_AXI_DATA_W-1:0]   wdata,
    input  logic [`VS_AXI_DATA_W/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`VS_AXI_ADDR_W-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`VS_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    logic       start;
    logic       busy;
    slide_op_e  op;
    vreg_idx_t  vd;
    vreg_idx_t  vs2;
    vl_t        vl;
    offset_t    offset;
    elem_t      rs1;
    logic       elem_we;
    logic [6:0] elem_addr;
    elem_t      elem_wdata;
    elem_t      elem_rdata;
    vreg_idx_t  src_idx;
    chunk_idx_t src_chunk;
    chunk_t     src_data;
    chunk_t     scratch;
    chunk_idx_t uop_num;
    logic       uop_first;
    logic       uop_last;
    logic       wr_en;
    vreg_idx_t  wr_reg;
    chunk_idx_t wr_chunk;
    chunk_t     chunk_out;
    lane_mask_t mask_out;

    vslide_axil_regs u_regs (
        .CLK, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .elem_rdata,
        .start, .op, .vd, .vs2, .vl, .offset, .rs1,
        .elem_we, .elem_addr, .elem_wdata
    );

    vector_regfile u_regfile (
        .CLK, .rst_n,
        .rd_reg   (src_idx),
        .rd_chunk (src_chunk),
        .rd_data  (src_data),
        .wr_en, .wr_reg, .wr_chunk,
        .wr_mask  (mask_out),
        .wr_data  (chunk_out),
        .elem_we, .elem_addr, .elem_wdata, .elem_rdata
    );

    vslide_sequencer u_seq (
        .CLK, .rst_n,
        .start, .op, .vd, .vs2, .vl, .offset,
        .chunk_in (src_data),
        .busy, .src_idx, .src_chunk, .scratch,
        .uop_num, .uop_first, .uop_last,
        .wr_en, .wr_reg, .wr_chunk
    );

    vslide_permutation_unit u_perm (
        .op, .uop_num, .uop_first, .uop_last,
        .vs2_chunk (src_data),
        .scratch, .rs1, .offset, .vl,
        .chunk_out, .mask_out
    );

endmodule

/* rtl/vslide_permutation_unit.sv */
// Combinational permutation unit, forms one destination chunk and its lane write mask.
`include "vslide_defines.svh"

module vslide_permutation_unit
    import vslide_pkg::*;
(
    input  slide_op_e  op,
    input  chunk_idx_t uop_num,
    input  logic       uop_first,
    input  logic       uop_last,
    input  chunk_t     vs2_chunk,
    input  chunk_t     scratch,
    input  elem_t      rs1,
    input  offset_t    offset,
    input  vl_t        vl,
    output chunk_t     chunk_out,
    output lane_mask_t mask_out
);

    logic    slide_up;
    offset_t slide_amt;    // Elements moved, one for the slide1 forms.
    vl_t     last_idx;

    assign slide_up  = (op == SLIDE_UP) || (op == SLIDE1_UP);
    assign slide_amt = op[1] ? offset_t'(1) : offset;
    assign last_idx  = vl - 1'b1;

    always_comb begin
        logic [1:0] lane;
        logic [3:0] idx;
        for (int j = 0; j < `VS_LANES; j++) begin
            idx = {uop_num, 2'(j)};    // Destination element index.
            if (slide_up) begin
                // Low lanes come from the tail of the previous chunk.
                lane         = 2'(j) - slide_amt[1:0];
                chunk_out[j] = (2'(j) >= slide_amt[1:0]) ? vs2_chunk[lane] : scratch[lane];
                mask_out[j]  = (op == SLIDE1_UP) || ({1'b0, idx} >= slide_amt);
            end else begin
                lane         = 2'(j) + slide_amt[1:0];
                chunk_out[j] = (3'(j) + 3'(slide_amt[1:0]) < 3'(`VS_LANES)) ?
                               scratch[lane] : vs2_chunk[lane];
                if (6'(idx) + 6'(slide_amt) >= 6'(`VS_VLMAX)) begin
                    chunk_out[j] = '0;    // Source lies past the register.
                end
                mask_out[j]  = 1'b1;
            end

            if (op == SLIDE1_UP && uop_first && j == 0) begin
                chunk_out[j] = rs1;
            end
            if (op == SLIDE1_DOWN && uop_last && 2'(j) == last_idx[1:0]) begin
                chunk_out[j] = rs1;    // Scalar goes into element vl - 1.
            end

            // Tail at vl and above stays undisturbed.
            mask_out[j] = mask_out[j] && ({1'b0, idx} < vl);
        end
    end

endmodule

/* rtl/vslide_sequencer.sv */
// Slide sequencer, walks source chunks of one command and issues four chunk write-backs.
`include "vslide_defines.svh"

module vslide_sequencer
    import vslide_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       start,
    input  slide_op_e  op,
    input  vreg_idx_t  vd,
    input  vreg_idx_t  vs2,
    input  vl_t        vl,
    input  offset_t    offset,
    input  chunk_t     chunk_in,
    output logic       busy,
    output vreg_idx_t  src_idx,
    output chunk_idx_t src_chunk,
    output chunk_t     scratch,
    output chunk_idx_t uop_num,
    output logic       uop_first,
    output logic       uop_last,
    output logic       wr_en,
    output vreg_idx_t  wr_reg,
    output chunk_idx_t wr_chunk
);

    slide_op_e  op_q;
    vreg_idx_t  vd_q;
    vreg_idx_t  vs2_q;
    chunk_idx_t chunk_skip;    // Whole chunks moved by the slide.
    logic [2:0] step;          // 0 primes scratch, 1 to 4 are micro-ops.
    vl_t        last_elem;
    logic       slide_up;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            step       <= '0;
            op_q       <= SLIDE_UP;
            vd_q       <= '0;
            vs2_q      <= '0;
            chunk_skip <= '0;
        end else if (start) begin
            busy       <= 1'b1;
            step       <= '0;
            op_q       <= op;
            vd_q       <= vd;
            vs2_q      <= vs2;
            chunk_skip <= op[1] ? '0 : offset[3:2];    // Slide1 moves by one lane only.
        end else if (busy) begin
            step <= step + 3'd1;
            busy <= (step != 3'd4);
        end
    end

    // Previous source chunk, combined with the current one by the permutation unit.
    always_ff @(posedge CLK) begin
        if (busy) scratch <= chunk_in;
    end

    assign slide_up = (op_q == SLIDE_UP) || (op_q == SLIDE1_UP);

    // Up walks from the chunk below, down from the chunk above.
    // Indices past either end wrap; those lanes are masked or zeroed downstream.
    assign src_idx   = vs2_q;
    assign src_chunk = slide_up ? step[1:0] - 2'd1 - chunk_skip : step[1:0] + chunk_skip;

    assign uop_num   = chunk_idx_t'(step - 3'd1);
    assign wr_en     = busy && (step != 3'd0);
    assign uop_first = wr_en && (step == 3'd1);
    assign last_elem = vl - 1'b1;
    assign uop_last  = wr_en && (uop_num == last_elem[3:2]);    // Chunk that holds vl - 1.
    assign wr_reg    = vd_q;
    assign wr_chunk  = uop_num;

    a_busy_len: assert property (@(posedge CLK) disable iff (!rst_n)
        $rose(busy) |-> ##[1:5] !busy)
        else $error("Slide ran longer than five cycles.");

    // The host interface refuses commands while a slide runs.
    a_no_restart: assert property (@(posedge CLK) disable iff (!rst_n)
        start |-> !busy)
        else $error("Start arrived during a running slide.");

endmodule

/* rtl/vector_regfile.sv */
// Vector register file with a chunk read port, a lane-masked chunk write port and a host port.
`include "vslide_defines.svh"

module vector_regfile
    import vslide_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  vreg_idx_t  rd_reg,
    input  chunk_idx_t rd_chunk,
    output chunk_t     rd_data,
    input  logic       wr_en,
    input  vreg_idx_t  wr_reg,
    input  chunk_idx_t wr_chunk,
    input  lane_mask_t wr_mask,
    input  chunk_t     wr_data,
    input  logic       elem_we,
    input  logic [6:0] elem_addr,    // {vreg, chunk, lane}.
    input  elem_t      elem_wdata,
    output elem_t      elem_rdata
);

    chunk_t mem [`VS_NUM_VREGS][`VS_VLMAX/`VS_LANES];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};
        end else if (wr_en) begin
            for (int l = 0; l < `VS_LANES; l++) begin
                if (wr_mask[l]) mem[wr_reg][wr_chunk][l] <= wr_data[l];    // Masked lanes keep old data.
            end
        end else if (elem_we) begin
            mem[elem_addr[6:4]][elem_addr[3:2]][elem_addr[1:0]] <= elem_wdata;
        end
    end

    assign rd_data    = mem[rd_reg][rd_chunk];
    assign elem_rdata = mem[elem_addr[6:4]][elem_addr[3:2]][elem_addr[1:0]];

    // Host window writes are refused while the engine runs.
    a_port_excl: assert property (@(posedge CLK) disable iff (!rst_n)
        !(elem_we && wr_en))
        else $error("Host write collided with engine write-back.");

endmodule

/* rtl/vslide_axil_regs.sv */
// AXI4-Lite slave of the slide engine that holds the command registers and the element window.
`include "vslide_defines.svh"

module vslide_axil_regs
    import vslide_pkg::*;
(
    input  logic                        CLK,
    input  logic                        rst_n,
    input  logic [`VS_AXI_ADDR_W-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`VS_AXI_DATA_W-1:0]   wdata,
    input  logic [`VS_AXI_DATA_W/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`VS_AXI_ADDR_W-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`VS_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        busy,
    input  elem_t                       elem_rdata,
    output logic                        start,
    output slide_op_e                   op,
    output vreg_idx_t                   vd,
    output vreg_idx_t                   vs2,
    output vl_t                         vl,
    output offset_t                     offset,
    output elem_t                       rs1,
    output logic                        elem_we,
    output logic [6:0]                  elem_addr,
    output elem_t                       elem_wdata
);

    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_CMD    = 'h000;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_VL     = 'h004;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_OFFSET = 'h008;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_RS1    = 'h00C;
    localparam logic [`VS_AXI_ADDR_W-1:0] ADDR_STATUS = 'h010;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic wr_hs;     // Write address and data accepted this cycle.
    logic rd_hs;
    logic wr_win;
    logic rd_win;
    logic cmd_ok;

    assign wr_hs  = awready;
    assign wready = awready;    // Both channels are taken together.

    // Window covers 0x200 to 0x3FC.
    assign wr_win = (awaddr[`VS_AXI_ADDR_W-1:9] == 'd1);
    assign rd_win = (araddr[`VS_AXI_ADDR_W-1:9] == 'd1);

    assign cmd_ok = !busy && (wdata[6:4] != wdata[10:8]);

    // The element port is shared, so a read waits out a write handshake.
    assign arready = !rvalid && !awready;
    assign rd_hs   = arvalid && arready;

    assign elem_we    = wr_hs && wr_win && !busy;
    assign elem_addr  = wr_hs ? awaddr[8:2] : araddr[8:2];    // {vreg, element}.
    assign elem_wdata = wdata;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
            rdata   <= '0;
            start   <= 1'b0;
            op      <= SLIDE_UP;
            vd      <= '0;
            vs2     <= '0;
            vl      <= '0;
            offset  <= '0;
            rs1     <= '0;
        end else begin
            start   <= 1'b0;
            awready <= awvalid && wvalid && !bvalid && !awready;    // One-cycle pulse.

            if (bvalid && bready) bvalid <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;

            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                case (awaddr)
                    ADDR_CMD: begin
                        if (cmd_ok) begin
                            start <= 1'b1;
                            op    <= slide_op_e'(wdata[1:0]);
                            vd    <= wdata[6:4];
                            vs2   <= wdata[10:8];
                        end else begin
                            bresp <= RESP_SLVERR;    // Busy or vd overlaps vs2.
                        end
                    end
                    ADDR_VL:     vl     <= (wdata > `VS_VLMAX) ? vl_t'(`VS_VLMAX) : vl_t'(wdata);
                    ADDR_OFFSET: offset <= wdata[4:0];
                    ADDR_RS1:    rs1    <= wdata;
                    default: begin
                        if (!wr_win || busy) bresp <= RESP_SLVERR;
                    end
                endcase
            end

            if (rd_hs) begin
                rvalid <= 1'b1;
                rresp  <= RESP_OKAY;
                case (araddr)
                    ADDR_VL:     rdata <= 32'(vl);
                    ADDR_OFFSET: rdata <= 32'(offset);
                    ADDR_RS1:    rdata <= rs1;
                    ADDR_STATUS: rdata <= 32'(busy);
                    default: begin
                        rdata <= rd_win ? elem_rdata : '0;
                        if (!rd_win) rresp <= RESP_SLVERR;    // CMD reads land here too.
                    end
                endcase
            end
        end
    end

    // The response code holds with bvalid until the master takes it.
    a_bvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("Write response withdrawn or changed before bready.");

    // Only full-word writes are supported.
    a_full_strobe: assert property (@(posedge CLK) disable iff (!rst_n)
        wr_hs |-> (wstrb == '1))
        else $error("Partial write strobe on the host bus.");

endmodule

/* rtl/vslide_pkg.sv */
// Element, chunk, index and opcode types shared by the slide engine and its testbench.
`include "vslide_defines.svh"

package vslide_pkg;

    typedef logic [31:0] elem_t;

    // Lane 0 holds the lowest element index of the chunk.
    typedef elem_t chunk_t [`VS_LANES];

    typedef logic [`VS_LANES-1:0] lane_mask_t;    // Bit i writes lane i.

    typedef logic [$clog2(`VS_NUM_VREGS)-1:0] vreg_idx_t;
    typedef logic [$clog2(`VS_VLMAX/`VS_LANES)-1:0] chunk_idx_t;

    typedef logic [$clog2(`VS_VLMAX):0] vl_t;    // 0 to 16.
    typedef logic [4:0] offset_t;

    typedef enum logic [1:0] {
        SLIDE_UP    = 2'd0,
        SLIDE_DOWN  = 2'd1,
        SLIDE1_UP   = 2'd2,
        SLIDE1_DOWN = 2'd3
    } slide_op_e;

endpackage

/* rtl/vslide_defines.svh */
// Sizing macros for the vector slide engine, included by the package and by every RTL file.
`ifndef VSLIDE_DEFINES_SVH
`define VSLIDE_DEFINES_SVH

// Elements handled per chunk and per micro-op.
`define VS_LANES 4

// Elements in one vector register.
`define VS_VLMAX 16

// Architectural vector registers.
`define VS_NUM_VREGS 8

// Host bus widths.
`define VS_AXI_ADDR_W 12
`define VS_AXI_DATA_W 32

`endif
